//--- src/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Datapath sizes.
`define DATA_W 32
`define REG_CNT 16

// Bus address map.
`define ADR_W 5
`define ADR_INSTR 5'h00
`define ADR_FLAGS 5'h01
// R0 to R15 sit at 0x10 to 0x1F.
`define ADR_REGBASE 5'h10

`endif

//--- src/CorePkg.sv
`default_nettype none

`include "core_consts.svh"

package CorePkg;

    typedef logic [`DATA_W-1:0] dataWord;
    typedef logic [`DATA_W-1:0] instrWord;
    typedef logic [$clog2(`REG_CNT)-1:0] regAddr;
    // N, Z, C, V from bit 3 down.
    typedef logic [3:0] flagsVec;
    typedef logic [4:0] shamtVec;

    typedef enum logic [3:0] {
        EQ, NE, CS, CC, MI, PL, VS, VC,
        HI, LS, GE, LT, GT, LE, AL, NV
    } condCode;

    // ADC, SBC and RSC (0101 to 0111) all execute as NOP.
    typedef enum logic [3:0] {
        AND = 4'b0000, EOR = 4'b0001, SUB = 4'b0010, RSB = 4'b0011,
        ADD = 4'b0100, NOP = 4'b0101,
        TST = 4'b1000, TEQ = 4'b1001, CMP = 4'b1010, CMN = 4'b1011,
        ORR = 4'b1100, MOV = 4'b1101, BIC = 4'b1110, MVN = 4'b1111
    } aluOp;

    typedef enum logic [1:0] {LSL, LSR, ASR, ROR} shiftKind;

    typedef enum logic [1:0] {Idle, Issue, ReadWait, Ack} busState;

endpackage

`default_nettype wire

//--- src/PipeIfs.sv
`timescale 1ns/1ps
`default_nettype none

interface DecodeExecIf;
    import CorePkg::*;

    logic     valid;
    condCode  cond;
    aluOp     op;
    logic     setFlags;
    logic     writesReg;
    regAddr   rd;
    dataWord  opA;
    dataWord  opB;
    logic     useImm;
    shiftKind sh;
    shamtVec  shamt;

    modport Producer (
        output valid, cond, op, setFlags, writesReg, rd,
        output opA, opB, useImm, sh, shamt
    );

    modport Consumer (
        input valid, cond, op, setFlags, writesReg, rd,
        input opA, opB, useImm, sh, shamt
    );

endinterface

interface ExecResultIf;
    import CorePkg::*;

    logic    valid;
    logic    regWrite;
    regAddr  rd;
    dataWord result;

    modport Producer (
        output valid, regWrite, rd, result
    );

    modport Consumer (
        input valid, regWrite, rd, result
    );

endinterface

`default_nettype wire

//--- src/InstrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module InstrDecoder (
    input  logic              CLK,
    input  logic              Reset,
    input  logic              instrLoad,
    input  CorePkg::instrWord instrWord,
    output logic              slotFree,
    output logic              pipeIdle,
    output CorePkg::regAddr   rnAddr,
    output CorePkg::regAddr   rmAddr,
    input  CorePkg::dataWord  rnData,
    input  CorePkg::dataWord  rmData,
    DecodeExecIf.Producer     dIf,
    input  CorePkg::regAddr   deRd,
    input  CorePkg::regAddr   rsRd,
    input  logic              deWrites,
    input  logic              rsWrites,
    input  logic              resultBusy
);
    import CorePkg::*;

    logic              slotFull;
    CorePkg::instrWord slotInstr;
    logic              deBusy;
    logic              isNop;
    logic              isCompare;
    logic              usesRn;
    logic              usesRm;
    logic              hazard;

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            slotFull <= 1'b0;
            deBusy   <= 1'b0;
        end else begin
            if (instrLoad)
                slotFull <= 1'b1;
            else if (dIf.valid)
                slotFull <= 1'b0;
            // Mirrors the valid bit now held in the DE register.
            deBusy <= dIf.valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (instrLoad)
            slotInstr <= instrWord;
    end

    assign rnAddr = slotInstr[19:16];
    assign rmAddr = slotInstr[3:0];

    assign isNop     = slotInstr[24:21] inside {4'b0101, 4'b0110, 4'b0111};
    assign isCompare = slotInstr[24:23] == 2'b10;
    assign usesRn    = !(dIf.op == MOV || dIf.op == MVN);
    assign usesRm    = !dIf.useImm;

    // Stall while a source is still waiting to be written back.
    assign hazard = (usesRn && ((deWrites && deRd == rnAddr) || (rsWrites && rsRd == rnAddr)))
                 || (usesRm && ((deWrites && deRd == rmAddr) || (rsWrites && rsRd == rmAddr)));

    assign dIf.valid     = slotFull && !hazard;
    assign dIf.cond      = condCode'(slotInstr[31:28]);
    assign dIf.op        = aluOp'(slotInstr[24:21]);
    assign dIf.setFlags  = !isNop && (slotInstr[20] || isCompare);
    assign dIf.writesReg = !isNop && !isCompare;
    assign dIf.rd        = slotInstr[15:12];
    assign dIf.useImm    = slotInstr[25];
    assign dIf.sh        = shiftKind'(slotInstr[6:5]);
    assign dIf.shamt     = slotInstr[11:7];
    assign dIf.opA       = rnData;
    assign dIf.opB       = dIf.useImm ? dataWord'(slotInstr[7:0]) : rmData;

    assign slotFree = !slotFull;
    assign pipeIdle = !slotFull && !deBusy && !resultBusy;

endmodule

`default_nettype wire

//--- src/DecodeExecReg.sv
`timescale 1ns/1ps
`default_nettype none

module DecodeExecReg (
    input  logic            CLK,
    input  logic            Reset,
    DecodeExecIf.Consumer   dIf,
    DecodeExecIf.Producer   eIf,
    output CorePkg::regAddr deRd,
    output logic            deWrites
);
    import CorePkg::*;

    // Loads every cycle. An empty decode slot becomes a bubble.
    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            eIf.valid     <= 1'b0;
            eIf.setFlags  <= 1'b0;
            eIf.writesReg <= 1'b0;
            eIf.cond      <= EQ;
            eIf.op        <= AND;
            eIf.rd        <= '0;
            eIf.opA       <= '0;
            eIf.opB       <= '0;
            eIf.useImm    <= 1'b0;
            eIf.sh        <= LSL;
            eIf.shamt     <= '0;
        end else begin
            eIf.valid     <= dIf.valid;
            // Control bits are masked so a bubble cannot write anything.
            eIf.setFlags  <= dIf.valid && dIf.setFlags;
            eIf.writesReg <= dIf.valid && dIf.writesReg;
            eIf.cond      <= dIf.cond;
            eIf.op        <= dIf.op;
            eIf.rd        <= dIf.rd;
            eIf.opA       <= dIf.opA;
            eIf.opB       <= dIf.opB;
            eIf.useImm    <= dIf.useImm;
            eIf.sh        <= dIf.sh;
            eIf.shamt     <= dIf.shamt;
        end
    end

    // Destination seen by the hazard check.
    assign deRd     = eIf.rd;
    assign deWrites = eIf.writesReg;

endmodule

`default_nettype wire

//--- src/ExecuteUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module ExecuteUnit (
    input  logic             CLK,
    input  logic             Reset,
    DecodeExecIf.Consumer    eIf,
    ExecResultIf.Producer    rIf,
    output CorePkg::flagsVec flags
);
    import CorePkg::*;

    dataWord          shifted;
    dataWord          srcB;
    dataWord          addA;
    dataWord          addB;
    logic             carryIn;
    logic [`DATA_W:0] sum;
    logic             overflow;
    logic             isArith;
    dataWord          result;
    logic             condPass;
    flagsVec          newFlags;

    always_comb begin
        if (eIf.shamt == '0) begin
            shifted = eIf.opB;
        end else begin
            case (eIf.sh)
                LSL:     shifted = eIf.opB << eIf.shamt;
                LSR:     shifted = eIf.opB >> eIf.shamt;
                ASR:     shifted = $signed(eIf.opB) >>> eIf.shamt;
                default: shifted = (eIf.opB >> eIf.shamt) | (eIf.opB << (6'd32 - eIf.shamt));
            endcase
        end
    end

    assign srcB = eIf.useImm ? eIf.opB : shifted;

    // Subtraction is done as A + ~B + 1, so carry out is not-borrow.
    always_comb begin
        addA    = eIf.opA;
        addB    = srcB;
        carryIn = 1'b0;
        case (eIf.op)
            SUB, CMP: begin
                addB    = ~srcB;
                carryIn = 1'b1;
            end
            RSB: begin
                addA    = srcB;
                addB    = ~eIf.opA;
                carryIn = 1'b1;
            end
            default: ;
        endcase
    end

    assign sum      = {1'b0, addA} + {1'b0, addB} + {{`DATA_W{1'b0}}, carryIn};
    assign overflow = (addA[`DATA_W-1] == addB[`DATA_W-1])
                   && (sum[`DATA_W-1] != addA[`DATA_W-1]);
    assign isArith  = eIf.op inside {SUB, RSB, ADD, CMP, CMN};

    always_comb begin
        case (eIf.op)
            AND, TST: result = eIf.opA & srcB;
            EOR, TEQ: result = eIf.opA ^ srcB;
            ORR:      result = eIf.opA | srcB;
            MOV:      result = srcB;
            BIC:      result = eIf.opA & ~srcB;
            MVN:      result = ~srcB;
            SUB, RSB, ADD, CMP, CMN: result = sum[`DATA_W-1:0];
            default:  result = eIf.opA;
        endcase
    end

    always_comb begin
        case (eIf.cond)
            EQ: condPass = flags[2];
            NE: condPass = !flags[2];
            CS: condPass = flags[1];
            CC: condPass = !flags[1];
            MI: condPass = flags[3];
            PL: condPass = !flags[3];
            VS: condPass = flags[0];
            VC: condPass = !flags[0];
            HI: condPass = flags[1] && !flags[2];
            LS: condPass = !flags[1] || flags[2];
            GE: condPass = flags[3] == flags[0];
            LT: condPass = flags[3] != flags[0];
            GT: condPass = !flags[2] && (flags[3] == flags[0]);
            LE: condPass = flags[2] || (flags[3] != flags[0]);
            AL: condPass = 1'b1;
            default: condPass = 1'b0;
        endcase
    end

    // Logical operations keep C and V.
    assign newFlags = {result[`DATA_W-1], result == '0,
                       isArith ? sum[`DATA_W] : flags[1],
                       isArith ? overflow : flags[0]};

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset)
            flags <= '0;
        else if (eIf.valid && condPass && eIf.setFlags)
            flags <= newFlags;
    end

    assign rIf.valid    = eIf.valid;
    assign rIf.regWrite = eIf.valid && condPass && eIf.writesReg;
    assign rIf.rd       = eIf.rd;
    assign rIf.result   = result;

endmodule

`default_nettype wire

//--- src/ResultStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module ResultStage (
    input  logic             CLK,
    input  logic             Reset,
    ExecResultIf.Consumer    rIf,
    input  CorePkg::regAddr  rnAddr,
    input  CorePkg::regAddr  rmAddr,
    input  CorePkg::regAddr  rdAddrBus,
    output CorePkg::dataWord rnData,
    output CorePkg::dataWord rmData,
    output CorePkg::dataWord rdDataBus,
    output CorePkg::regAddr  rsRd,
    output logic             rsWrites,
    output logic             resultBusy
);
    import CorePkg::*;

    dataWord rsData;
    dataWord regFile [`REG_CNT];

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            resultBusy <= 1'b0;
            rsWrites   <= 1'b0;
            rsRd       <= '0;
        end else begin
            resultBusy <= rIf.valid;
            rsWrites   <= rIf.regWrite;
            rsRd       <= rIf.rd;
        end
    end

    always_ff @(posedge CLK) begin
        rsData <= rIf.result;
    end

    // Write back one cycle after execute.
    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < `REG_CNT; i++)
                regFile[i] <= '0;
        end else if (rsWrites) begin
            regFile[rsRd] <= rsData;
        end
    end

    assign rnData    = regFile[rnAddr];
    assign rmData    = regFile[rmAddr];
    assign rdDataBus = regFile[rdAddrBus];

endmodule

`default_nettype wire

//--- src/BusSlave.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module BusSlave (
    input  logic               CLK,
    input  logic               Reset,
    input  logic               wbCyc,
    input  logic               wbStb,
    input  logic               wbWe,
    input  logic [`ADR_W-1:0]  wbAdr,
    input  CorePkg::dataWord   wbDatIn,
    output CorePkg::dataWord   wbDatOut,
    output logic               wbAck,
    output logic               instrLoad,
    output CorePkg::instrWord  instrWord,
    input  logic               slotFree,
    input  logic               pipeIdle,
    output CorePkg::regAddr    rdAddrBus,
    input  CorePkg::dataWord   rdDataBus,
    input  CorePkg::flagsVec   flags
);
    import CorePkg::*;

    busState state;
    dataWord readData;

    always_comb begin
        if (wbAdr == `ADR_FLAGS)
            readData = dataWord'(flags);
        else if (wbAdr >= `ADR_REGBASE)
            readData = rdDataBus;
        else
            readData = '0;
    end

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            state    <= Idle;
            wbDatOut <= '0;
        end else begin
            case (state)
                Idle:
                    if (wbCyc && wbStb) begin
                        if (!wbWe)
                            state <= ReadWait;
                        else if (wbAdr == `ADR_INSTR && !slotFree)
                            state <= Issue;
                        else
                            state <= Ack;
                    end
                // Back-pressure until the decode slot empties.
                Issue:
                    if (slotFree)
                        state <= Ack;
                // Reads return retired state only.
                ReadWait:
                    if (pipeIdle) begin
                        wbDatOut <= readData;
                        state    <= Ack;
                    end
                default:
                    state <= Idle;
            endcase
        end
    end

    assign wbAck     = state == Ack;
    assign instrLoad = slotFree && ((state == Issue)
                    || (state == Idle && wbCyc && wbStb && wbWe && wbAdr == `ADR_INSTR));
    assign instrWord = wbDatIn;
    assign rdAddrBus = wbAdr[3:0];

endmodule

`default_nettype wire

//--- src/PipelineTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module PipelineTop (
    input  logic              CLK,
    input  logic              Reset,
    input  logic              wbCyc,
    input  logic              wbStb,
    input  logic              wbWe,
    input  logic [`ADR_W-1:0] wbAdr,
    input  CorePkg::dataWord  wbDatIn,
    output CorePkg::dataWord  wbDatOut,
    output logic              wbAck
);
    import CorePkg::*;

    logic    instrLoad;
    dataWord busInstr;
    logic    slotFree;
    logic    pipeIdle;
    regAddr  rdAddrBus;
    dataWord rdDataBus;
    flagsVec flags;
    regAddr  rnAddr;
    regAddr  rmAddr;
    dataWord rnData;
    dataWord rmData;
    regAddr  deRd;
    regAddr  rsRd;
    logic    deWrites;
    logic    rsWrites;
    logic    resultBusy;

    DecodeExecIf dIf ();
    DecodeExecIf eIf ();
    ExecResultIf rIf ();

    BusSlave busSlave (
        .CLK, .Reset, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatIn, .wbDatOut, .wbAck,
        .instrLoad, .instrWord(busInstr), .slotFree, .pipeIdle,
        .rdAddrBus, .rdDataBus, .flags
    );

    InstrDecoder instrDecoder (
        .CLK, .Reset, .instrLoad, .instrWord(busInstr), .slotFree, .pipeIdle,
        .rnAddr, .rmAddr, .rnData, .rmData, .dIf(dIf.Producer),
        .deRd, .rsRd, .deWrites, .rsWrites, .resultBusy
    );

    DecodeExecReg decodeExecReg (
        .CLK, .Reset, .dIf(dIf.Consumer), .eIf(eIf.Producer), .deRd, .deWrites
    );

    ExecuteUnit executeUnit (
        .CLK, .Reset, .eIf(eIf.Consumer), .rIf(rIf.Producer), .flags
    );

    ResultStage resultStage (
        .CLK, .Reset, .rIf(rIf.Consumer), .rnAddr, .rmAddr, .rdAddrBus,
        .rnData, .rmData, .rdDataBus, .rsRd, .rsWrites, .resultBusy
    );

endmodule

`default_nettype wire

//--- tests/PipelineTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module PipelineTb;
    import CorePkg::*;

    localparam int numInstr    = 200;
    localparam int numDirected = 10;
    localparam int numReads    = 110;
    // Every bus transfer finishes within 12 cycles, stalls included.
    localparam int cycleLimit  = (numInstr + numDirected + numReads) * 12 + 160;

    logic              CLK;
    logic              Reset;
    logic              wbCyc;
    logic              wbStb;
    logic              wbWe;
    logic [`ADR_W-1:0] wbAdr;
    dataWord           wbDatIn;
    dataWord           wbDatOut;
    logic              wbAck;

    logic [15:0] lfsrState;
    regAddr      lastRd;
    dataWord     modelRegs [`REG_CNT];
    flagsVec     modelFlags;
    int          cycleCount;

    PipelineTop DUT (
        .CLK, .Reset, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatIn, .wbDatOut, .wbAck
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    task automatic abortRun();
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped after an error.");
    endtask

    initial begin
        cycleCount = 0;
        forever begin
            @(posedge CLK);
            cycleCount++;
            if (cycleCount >= cycleLimit) begin
                $display("Timeout: the bus transfers did not finish within %0d cycles.",
                         cycleLimit);
                abortRun();
            end
        end
    end

    task automatic checkEqual(input string name, input dataWord expected, input dataWord actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            abortRun();
        end
    endtask

    // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11.
    function automatic logic nextRandomBit();
        logic feedback;
        feedback  = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
        lfsrState = {lfsrState[14:0], feedback};
        return feedback;
    endfunction

    function automatic dataWord randomBits(input int count);
        dataWord value;
        value = '0;
        for (int i = 0; i < count; i++)
            value = {value[30:0], nextRandomBit()};
        return value;
    endfunction

    function automatic logic condHolds(input logic [3:0] cond, input flagsVec f);
        logic n, z, c, v;
        {n, z, c, v} = f;
        case (cond)
            EQ: return z;
            NE: return !z;
            CS: return c;
            CC: return !c;
            MI: return n;
            PL: return !n;
            VS: return v;
            VC: return !v;
            HI: return c && !z;
            LS: return !c || z;
            GE: return n == v;
            LT: return n != v;
            GT: return !z && (n == v);
            LE: return z || (n != v);
            AL: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic dataWord shiftOperand(input dataWord value, input logic [1:0] kind,
                                             input shamtVec amount);
        logic [63:0] doubled;
        doubled = {value, value} >> amount;
        if (amount == 0)
            return value;
        case (kind)
            LSL: return value << amount;
            LSR: return value >> amount;
            ASR: return $signed(value) >>> amount;
            default: return doubled[31:0];
        endcase
    endfunction

    // Architectural effect of one instruction on the model state.
    task automatic applyInstr(input instrWord instr);
        logic [3:0]  op;
        logic        isCompare;
        logic        isNop;
        logic        c;
        logic        v;
        dataWord     a;
        dataWord     b;
        dataWord     r;
        logic [32:0] wide;
        op        = instr[24:21];
        isCompare = op[3:2] == 2'b10;
        isNop     = op inside {4'b0101, 4'b0110, 4'b0111};
        a         = modelRegs[instr[19:16]];
        if (instr[25])
            b = {24'b0, instr[7:0]};
        else
            b = shiftOperand(modelRegs[instr[3:0]], instr[6:5], instr[11:7]);
        {c, v} = modelFlags[1:0];
        r = a;
        case (op)
            AND, TST: r = a & b;
            EOR, TEQ: r = a ^ b;
            SUB, CMP: begin
                r = a - b;
                c = a >= b;
                v = (a[31] != b[31]) && (r[31] != a[31]);
            end
            RSB: begin
                r = b - a;
                c = b >= a;
                v = (a[31] != b[31]) && (r[31] != b[31]);
            end
            ADD, CMN: begin
                wide = {1'b0, a} + {1'b0, b};
                r    = wide[31:0];
                c    = wide[32];
                v    = (a[31] == b[31]) && (r[31] != a[31]);
            end
            ORR: r = a | b;
            MOV: r = b;
            BIC: r = a & ~b;
            MVN: r = ~b;
            default: ;
        endcase
        if (!isNop && condHolds(instr[31:28], modelFlags)) begin
            if (instr[20] || isCompare)
                modelFlags = {r[31], r == '0, c, v};
            if (!isCompare)
                modelRegs[instr[15:12]] = r;
        end
    endtask

    // Bus tasks are entered right after a falling edge.
    task automatic busWrite(input logic [`ADR_W-1:0] adr, input dataWord data);
        wbCyc   = 1'b1;
        wbStb   = 1'b1;
        wbWe    = 1'b1;
        wbAdr   = adr;
        wbDatIn = data;
        do @(negedge CLK); while (!wbAck);
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe  = 1'b0;
    endtask

    task automatic busRead(input logic [`ADR_W-1:0] adr, output dataWord data);
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe  = 1'b0;
        wbAdr = adr;
        do @(negedge CLK); while (!wbAck);
        data  = wbDatOut;
        wbCyc = 1'b0;
        wbStb = 1'b0;
    endtask

    task automatic sendInstr(input instrWord instr);
        busWrite(`ADR_INSTR, instr);
        applyInstr(instr);
    endtask

    task automatic checkRegister(input regAddr idx);
        dataWord data;
        busRead(`ADR_REGBASE + {1'b0, idx}, data);
        checkEqual($sformatf("wbDatOut (R%0d)", idx), modelRegs[idx], data);
    endtask

    task automatic checkAllRegisters();
        for (int i = 0; i < `REG_CNT; i++)
            checkRegister(regAddr'(i));
    endtask

    task automatic checkFlags();
        dataWord data;
        busRead(`ADR_FLAGS, data);
        checkEqual("wbDatOut (flags)", {28'b0, modelFlags}, data);
    endtask

    function automatic instrWord regInstr(input logic [3:0] cond, input logic [3:0] op,
                                          input logic s, input regAddr rd, input regAddr rn,
                                          input regAddr rm, input logic [1:0] sh,
                                          input shamtVec shamt);
        return {cond, 3'b000, op, s, rn, rd, shamt, sh, 1'b0, rm};
    endfunction

    function automatic instrWord immInstr(input logic [3:0] cond, input logic [3:0] op,
                                          input logic s, input regAddr rd, input regAddr rn,
                                          input logic [7:0] imm);
        return {cond, 3'b001, op, s, rn, rd, 4'h0, imm};
    endfunction

    function automatic instrWord randomInstr();
        logic [3:0]  cond;
        logic        useImm;
        logic [3:0]  op;
        logic        s;
        regAddr      rn;
        regAddr      rd;
        regAddr      rm;
        logic [11:0] operand;
        cond = AL;
        if (!nextRandomBit())
            cond = 4'(randomBits(4));
        useImm = nextRandomBit();
        op     = 4'(randomBits(4));
        s      = nextRandomBit();
        rn     = 4'(randomBits(3));
        rm     = 4'(randomBits(3));
        // Half the time a source is the previous destination.
        if (nextRandomBit()) begin
            if (nextRandomBit())
                rn = lastRd;
            else
                rm = lastRd;
        end
        rd = 4'(randomBits(3));
        if (useImm)
            operand = {4'h0, 8'(randomBits(8))};
        else
            operand = {5'(randomBits(5)), 2'(randomBits(2)), 1'b0, rm};
        lastRd = rd;
        return {cond, 2'b00, useImm, op, s, rn, rd, operand};
    endfunction

    initial begin : stimulus
        instrWord instr;
        dataWord  data;
        Reset      = 1'b1;
        wbCyc      = 1'b0;
        wbStb      = 1'b0;
        wbWe       = 1'b0;
        wbAdr      = '0;
        wbDatIn    = '0;
        lfsrState  = 16'd80;
        lastRd     = '0;
        modelFlags = '0;
        for (int i = 0; i < `REG_CNT; i++)
            modelRegs[i] = '0;
        repeat (8) @(posedge CLK);
        @(negedge CLK);
        Reset = 1'b0;

        checkAllRegisters();
        checkFlags();

        // Dependent chain through all four shift kinds.
        sendInstr(immInstr(AL, MOV, 1'b0, 4'd1, 4'd0, 8'h05));
        sendInstr(regInstr(AL, ADD, 1'b0, 4'd2, 4'd1, 4'd1, LSL, 5'd0));
        sendInstr(regInstr(AL, ADD, 1'b1, 4'd3, 4'd2, 4'd1, LSL, 5'd2));
        sendInstr(regInstr(AL, SUB, 1'b1, 4'd1, 4'd3, 4'd2, ASR, 5'd1));
        sendInstr(regInstr(AL, RSB, 1'b1, 4'd6, 4'd1, 4'd3, ROR, 5'd4));
        sendInstr(regInstr(AL, MVN, 1'b0, 4'd7, 4'd0, 4'd6, LSR, 5'd3));
        sendInstr(regInstr(AL, CMP, 1'b0, 4'd0, 4'd1, 4'd1, LSL, 5'd0));
        checkFlags();
        // Failed condition, NOP opcode and test must not touch registers.
        sendInstr(immInstr(NE, MOV, 1'b0, 4'd4, 4'd0, 8'hAA));
        sendInstr(immInstr(AL, 4'b0110, 1'b1, 4'd5, 4'd1, 8'h33));
        sendInstr(regInstr(EQ, TEQ, 1'b1, 4'd0, 4'd7, 4'd6, LSL, 5'd0));
        checkAllRegisters();
        checkFlags();

        // Writes elsewhere than the instruction port are dropped.
        busWrite(5'h03, immInstr(AL, MOV, 1'b0, 4'd9, 4'd0, 8'h5A));
        checkRegister(4'd9);
        busRead(5'h05, data);
        checkEqual("wbDatOut (unmapped 0x05)", 32'h0, data);

        for (int n = 0; n < numInstr; n++) begin
            instr = randomInstr();
            sendInstr(instr);
            if (n % 5 == 4)
                checkRegister(instr[15:12]);
            if (n % 20 == 19)
                checkFlags();
        end

        checkAllRegisters();
        checkFlags();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+src
src/CorePkg.sv
src/PipeIfs.sv
src/InstrDecoder.sv
src/DecodeExecReg.sv
src/ExecuteUnit.sv
src/ResultStage.sv
src/BusSlave.sv
src/PipelineTop.sv
tests/PipelineTb.sv

//--- Bender.yml
package:
  name: pipeline_slice

sources:
  - include_dirs:
      - src
    files:
      - src/CorePkg.sv
      - src/PipeIfs.sv
      - src/InstrDecoder.sv
      - src/DecodeExecReg.sv
      - src/ExecuteUnit.sv
      - src/ResultStage.sv
      - src/BusSlave.sv
      - src/PipelineTop.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/PipelineTb.sv
